// File: vlog.f
+incdir+.
icache_pkg.sv
icache_req_buf.sv
icache_tag_array.sv
icache_data_array.sv
icache_ctrl.sv
icache_top.sv
icache_asserts.sv
icache_tb.sv

// File: Makefile
# Verilator flow for the icache testbench

VERILATOR ?= verilator
TOP       ?= icache_tb
FILELIST  ?= vlog.f
BUILD_DIR ?= obj_dir
LINT_OPTS ?= --lint-only -Wall --timing
SIM_OPTS  ?= --binary --timing --assert -j 0
RUN_ARGS  ?= +verilator+error+limit+1000
PASS_MSG  ?= Regression passed

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_OPTS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_OPTS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)
	@out="$$(./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

// File: icache_tb.sv
// icache testbench: drives fetch and invalidate traffic, models memory, checks every response
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_tb;

    localparam logic [31:0] SEED     = 32'h6bab;
    localparam logic [31:0] WORD_KEY = 32'h5a3c_96e1;
    localparam int OP_COUNT = 4 + 2 + 6 + 5 + 200;
    // accept, lookup, address wait, data wait, refill, stalled response
    localparam int OP_WORST_CYCLES = 20;
    localparam int TIMEOUT_CYCLES  = 4 * OP_COUNT * OP_WORST_CYCLES;

    logic clk = 1'b0;
    logic rst_n, req_valid, req_ready, resp_valid, resp_ready;
    logic mem_req, mem_addr_ok, mem_data_ok, stall_en;
    icache_pkg::fetch_req_t  req;
    icache_pkg::fetch_resp_t resp;
    icache_pkg::mem_req_t    mem_addr;
    logic [`ICACHE_LINE_W-1:0] mem_line;

    // expectations in issue order
    icache_pkg::fetch_resp_t exp_resp_q[$];
    int    exp_mem_q[$];
    string name_q[$];

    // shadow copy of the cache state
    logic [`ICACHE_TAG_W-1:0] sh_tag [2][`ICACHE_SETS];
    logic sh_valid [2][`ICACHE_SETS];
    logic sh_lru [`ICACHE_SETS];

    int check_count = 0;
    int error_count = 0;
    int cycle_count = 0;
    int mem_req_count = 0;
    logic [31:0] last_mem_addr;

    always #20 clk = ~clk;

    icache_top icache_top_i (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req(req), .req_ready(req_ready),
        .resp_valid(resp_valid), .resp(resp), .resp_ready(resp_ready),
        .mem_req(mem_req), .mem_addr(mem_addr), .mem_addr_ok(mem_addr_ok),
        .mem_data_ok(mem_data_ok), .mem_line(mem_line)
    );

    bind icache_top icache_asserts asserts_i (
        .clk(clk), .rst_n(rst_n), .resp_valid(resp_valid), .resp_ready(resp_ready),
        .resp(resp), .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok)
    );

    //////////////////////////////////////////////////////////////////////
    // reference model
    //////////////////////////////////////////////////////////////////////

    function automatic logic [31:0] mem_word(input logic [31:0] addr);
        return addr ^ WORD_KEY;
    endfunction

    // even word offset gives a pair, odd offset one word with zero above
    function automatic icache_pkg::fetch_resp_t expected_resp(input logic [31:0] pc);
        icache_pkg::fetch_resp_t r;
        r.pc = pc;
        if (!pc[2]) begin
            r.insn       = {mem_word(pc + 32'd4), mem_word(pc)};
            r.pair_valid = 1'b1;
        end else begin
            r.insn       = {32'h0, mem_word(pc)};
            r.pair_valid = 1'b0;
        end
        return r;
    endfunction

    // returns hit, and moves the shadow state the way the cache should
    function automatic logic shadow_access(input logic [31:0] addr);
        logic [`ICACHE_INDEX_W-1:0] idx;
        logic [`ICACHE_TAG_W-1:0]   tag;
        logic way;
        logic hit;
        idx = addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
        tag = addr[31:`ICACHE_TAG_LSB];
        hit = 1'b0;
        way = 1'b0;
        for (int w = 0; w < 2; w++) begin
            if (sh_valid[w][idx] && sh_tag[w][idx] == tag) begin
                hit = 1'b1;
                way = w[0];
            end
        end
        if (!hit) begin
            // empty way first, then least recently used
            way = !sh_valid[0][idx] ? 1'b0 : !sh_valid[1][idx] ? 1'b1 : sh_lru[idx];
            sh_tag[way][idx]   = tag;
            sh_valid[way][idx] = 1'b1;
        end
        sh_lru[idx] = ~way;
        return hit;
    endfunction

    task automatic check(input string name, input logic [127:0] expected,
                         input logic [127:0] actual);
        check_count++;
        if (expected !== actual) begin
            error_count++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // request side
    //////////////////////////////////////////////////////////////////////

    task automatic issue(input string name, input icache_pkg::icache_op_e op,
                         input logic [31:0] addr);
        logic hit;
        if (op == icache_pkg::OP_FETCH) begin
            hit = shadow_access(addr);
            exp_resp_q.push_back(expected_resp(addr));
            exp_mem_q.push_back(hit ? 0 : 1);
            name_q.push_back(name);
        end else begin
            sh_valid[0][addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB]] = 1'b0;
            sh_valid[1][addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB]] = 1'b0;
        end
        @(negedge clk);
        req_valid = 1'b1;
        req.op    = op;
        req.addr  = addr;
        while (!req_ready) @(negedge clk);
        // taken at the rising edge just passed
        @(negedge clk);
        req_valid = 1'b0;
    endtask

    // memory: accept after 0 to 3 cycles, data 1 to 4 cycles after that
    initial begin : memory_model
        int wait_cycles;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_line    = '0;
        forever begin
            @(negedge clk);
            if (mem_req) begin
                wait_cycles = $urandom % 4;
                repeat (wait_cycles) @(negedge clk);
                last_mem_addr = mem_addr.addr;
                mem_req_count = mem_req_count + 1;
                mem_addr_ok   = 1'b1;
                @(negedge clk);
                mem_addr_ok = 1'b0;
                wait_cycles = 1 + $urandom % 4;
                repeat (wait_cycles - 1) @(negedge clk);
                for (int i = 0; i < 4; i++) begin
                    mem_line[32*i +: 32] = mem_word(last_mem_addr + 32'(4 * i));
                end
                mem_data_ok = 1'b1;
                @(negedge clk);
                mem_data_ok = 1'b0;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // response side
    //////////////////////////////////////////////////////////////////////

    initial begin : compare_responses
        icache_pkg::fetch_resp_t exp;
        string name;
        int exp_mem;
        int mem_seen;
        mem_seen   = 0;
        resp_ready = 1'b0;
        forever begin
            @(negedge clk);
            resp_ready = stall_en ? ($urandom % 4 != 0) : 1'b1;
            if (resp_valid && resp_ready) begin
                if (exp_resp_q.size() == 0) begin
                    error_count++;
                    $display("Response for pc %h arrived with no fetch outstanding", resp.pc);
                end else begin
                    exp     = exp_resp_q.pop_front();
                    exp_mem = exp_mem_q.pop_front();
                    name    = name_q.pop_front();
                    check(name, 128'(exp), 128'(resp));
                    check({name, " mem requests"}, 128'(exp_mem), 128'(mem_req_count - mem_seen));
                    if (exp_mem == 1) begin
                        check({name, " mem address"}, 128'(exp.pc & ~32'hf), 128'(last_mem_addr));
                    end
                end
                mem_seen = mem_req_count;
            end
        end
    end

    initial begin : watchdog
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("Timeout after %0d cycles, %0d responses never arrived",
                 cycle_count, exp_resp_q.size());
        $display("checks: %0d, errors: %0d", check_count, error_count);
        $display("Regression failed");
        $finish;
    end

    initial begin : stimulus
        logic [31:0] addr;
        int assert_fails;
        void'($urandom(SEED));
        rst_n     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        stall_en  = 1'b0;
        for (int s = 0; s < `ICACHE_SETS; s++) begin
            sh_valid[0][s] = 1'b0;
            sh_valid[1][s] = 1'b0;
            sh_lru[s]      = 1'b0;
        end
        repeat (3) @(negedge clk);
        rst_n = 1'b1;

        // offsets 0 to 3, each in its own line
        for (int i = 0; i < 4; i++) begin
            issue("cold_offsets", icache_pkg::OP_FETCH, 32'h0000_1000 + 32'(i * 20));
        end
        issue("refetch_hit", icache_pkg::OP_FETCH, 32'h0000_1008);
        issue("refetch_hit", icache_pkg::OP_FETCH, 32'h0000_1034);

        // tags A B A C at set 5, then A again and B again
        issue("lru_evict", icache_pkg::OP_FETCH, 32'h0000_2050);
        issue("lru_evict", icache_pkg::OP_FETCH, 32'h0000_3050);
        issue("lru_evict", icache_pkg::OP_FETCH, 32'h0000_2054);
        issue("lru_evict", icache_pkg::OP_FETCH, 32'h0000_4058);
        issue("lru_evict", icache_pkg::OP_FETCH, 32'h0000_205c);
        issue("lru_evict", icache_pkg::OP_FETCH, 32'h0000_3050);

        issue("index_invalidate", icache_pkg::OP_FETCH, 32'h0000_5090);
        issue("index_invalidate", icache_pkg::OP_FETCH, 32'h0000_6090);
        issue("index_invalidate", icache_pkg::OP_INVALIDATE, 32'h0000_0090);
        issue("index_invalidate", icache_pkg::OP_FETCH, 32'h0000_5094);
        issue("index_invalidate", icache_pkg::OP_FETCH, 32'h0000_609c);

        // six tags over all sets so hits and evictions mix
        stall_en = 1'b1;
        repeat (200) begin
            addr = 32'h0001_0000 | (($urandom % 6) << 8) | (($urandom % 16) << 4)
                   | (($urandom % 4) << 2);
            issue("random_fetch", icache_pkg::OP_FETCH, addr);
        end
        while (exp_resp_q.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);

        assert_fails = icache_top_i.asserts_i.failures;
        $display("checks: %0d, errors: %0d, assertion failures: %0d",
                 check_count, error_count, assert_fails);
        if (error_count == 0 && assert_fails == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

// File: icache_asserts.sv
// icache protocol assertions: response hold under stall and memory handshake order
`timescale 1ns/100ps

module icache_asserts (
    input logic                    clk,
    input logic                    rst_n,
    input logic                    resp_valid,
    input logic                    resp_ready,
    input icache_pkg::fetch_resp_t resp,
    input logic                    mem_req,
    input icache_pkg::mem_req_t    mem_addr,
    input logic                    mem_addr_ok,
    input logic                    mem_data_ok
);

    int   failures = 0;
    logic mem_pending;

    // refill outstanding from address accept until data return
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            mem_pending <= 1'b0;
        end else if (mem_req && mem_addr_ok) begin
            mem_pending <= 1'b1;
        end else if (mem_data_ok) begin
            mem_pending <= 1'b0;
        end
    end

    resp_hold: assert property (@(posedge clk) disable iff (!rst_n)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else begin
            $error("response dropped or changed while stalled");
            failures++;
        end

    addr_hold: assert property (@(posedge clk) disable iff (!rst_n)
        mem_req && !mem_addr_ok |=> mem_req && $stable(mem_addr))
        else begin
            $error("memory request dropped or address changed before accept");
            failures++;
        end

    data_after_req: assert property (@(posedge clk) disable iff (!rst_n)
        mem_data_ok |-> mem_pending)
        else begin
            $error("memory data returned with no request outstanding");
            failures++;
        end

endmodule

// File: icache_top.sv
// icache top level: request buffer, tag and data arrays and controller on fetch and memory ports
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_top (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    input  icache_pkg::fetch_req_t    req,
    output logic                      req_ready,
    output logic                      resp_valid,
    output icache_pkg::fetch_resp_t   resp,
    input  logic                      resp_ready,
    output logic                      mem_req,
    output icache_pkg::mem_req_t      mem_addr,
    input  logic                      mem_addr_ok,
    input  logic                      mem_data_ok,
    input  logic [`ICACHE_LINE_W-1:0] mem_line
);

    icache_pkg::fetch_req_t     req_held;
    logic                       accept;
    logic [`ICACHE_INDEX_W-1:0] rd_index;
    logic [`ICACHE_INDEX_W-1:0] held_index;
    logic [`ICACHE_TAG_W-1:0]   held_tag;
    logic [1:0]                 hit;
    logic                       victim_way;
    logic [`ICACHE_LINE_W-1:0]  line0, line1, wr_line;
    logic                       wr_en, wr_way, use_en, use_way, inv_en;

    // arrays read with the live index, everything else uses the held one
    assign rd_index   = req.addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
    assign held_index = req_held.addr[`ICACHE_TAG_LSB-1:`ICACHE_INDEX_LSB];
    assign held_tag   = req_held.addr[31:`ICACHE_TAG_LSB];

    icache_req_buf req_buf_i (
        .clk(clk), .rst_n(rst_n), .accept(accept), .req_in(req), .req_held(req_held)
    );

    icache_tag_array tag_array_i (
        .clk(clk), .rst_n(rst_n),
        .rd_en(accept), .rd_index(rd_index), .cmp_tag(held_tag),
        .wr_en(wr_en), .wr_index(held_index), .wr_way(wr_way), .wr_tag(held_tag),
        .inv_en(inv_en), .inv_index(held_index),
        .use_en(use_en), .use_way(use_way),
        .hit(hit), .victim_way(victim_way)
    );

    icache_data_array data_array_i (
        .clk(clk), .rd_en(accept), .rd_index(rd_index),
        .wr_en(wr_en), .wr_index(held_index), .wr_way(wr_way), .wr_line(wr_line),
        .line0(line0), .line1(line1)
    );

    icache_ctrl ctrl_i (
        .clk(clk), .rst_n(rst_n),
        .req_valid(req_valid), .req_ready(req_ready), .req_held(req_held), .accept(accept),
        .hit(hit), .victim_way(victim_way), .line0(line0), .line1(line1),
        .mem_line(mem_line),
        .wr_en(wr_en), .wr_way(wr_way), .wr_line(wr_line),
        .use_en(use_en), .use_way(use_way), .inv_en(inv_en),
        .mem_req(mem_req), .mem_addr(mem_addr),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .resp_valid(resp_valid), .resp(resp), .resp_ready(resp_ready)
    );

endmodule

// File: icache_ctrl.sv
// icache controller: lookup, miss request, refill and response formatting FSM
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_ctrl (
    input  logic                      clk,
    input  logic                      rst_n,
    input  logic                      req_valid,
    output logic                      req_ready,
    input  icache_pkg::fetch_req_t    req_held,
    output logic                      accept,
    input  logic [1:0]                hit,
    input  logic                      victim_way,
    input  logic [`ICACHE_LINE_W-1:0] line0,
    input  logic [`ICACHE_LINE_W-1:0] line1,
    input  logic [`ICACHE_LINE_W-1:0] mem_line,
    output logic                      wr_en,
    output logic                      wr_way,
    output logic [`ICACHE_LINE_W-1:0] wr_line,
    output logic                      use_en,
    output logic                      use_way,
    output logic                      inv_en,
    output logic                      mem_req,
    output icache_pkg::mem_req_t      mem_addr,
    input  logic                      mem_addr_ok,
    input  logic                      mem_data_ok,
    output logic                      resp_valid,
    output icache_pkg::fetch_resp_t   resp,
    input  logic                      resp_ready
);

    icache_pkg::ctrl_state_e   state_q, state_nx;
    logic [`ICACHE_LINE_W-1:0] line_q;
    logic                      way_q;
    icache_pkg::fetch_resp_t   resp_q;
    logic                      is_inv;
    logic                      lookup_hit;

    // even offset gives a pair, odd offset a single word with zero above
    function automatic icache_pkg::fetch_resp_t format_resp(
        input logic [31:0]               pc,
        input logic [`ICACHE_LINE_W-1:0] line
    );
        icache_pkg::fetch_resp_t   r;
        logic [`ICACHE_OFFSET_W-1:0] off;
        off  = pc[`ICACHE_INDEX_LSB-1:2];
        r.pc = pc;
        if (!off[0]) begin
            r.insn       = line[off*32 +: 64];
            r.pair_valid = 1'b1;
        end else begin
            r.insn       = {32'h0, line[off*32 +: 32]};
            r.pair_valid = 1'b0;
        end
        return r;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // state machine
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        state_nx = state_q;
        case (state_q)
            icache_pkg::S_IDLE:      if (req_valid) state_nx = icache_pkg::S_LOOKUP;
            icache_pkg::S_LOOKUP: begin
                if (is_inv)      state_nx = icache_pkg::S_IDLE;
                else if (|hit)   state_nx = icache_pkg::S_RESP;
                else             state_nx = icache_pkg::S_MISS_REQ;
            end
            icache_pkg::S_MISS_REQ:  if (mem_addr_ok) state_nx = icache_pkg::S_MISS_WAIT;
            icache_pkg::S_MISS_WAIT: if (mem_data_ok) state_nx = icache_pkg::S_REFILL;
            icache_pkg::S_REFILL:    state_nx = icache_pkg::S_RESP;
            icache_pkg::S_RESP:      if (resp_ready) state_nx = icache_pkg::S_IDLE;
            default:                 state_nx = icache_pkg::S_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state_q <= icache_pkg::S_IDLE;
        end else begin
            state_q <= state_nx;
        end
    end

    // refill line, victim and response register
    always_ff @(posedge clk) begin
        if (state_q == icache_pkg::S_MISS_WAIT && mem_data_ok) begin
            line_q <= mem_line;
            way_q  <= victim_way;
        end
        if (lookup_hit) begin
            resp_q <= format_resp(req_held.addr, hit[1] ? line1 : line0);
        end else if (wr_en) begin
            resp_q <= format_resp(req_held.addr, line_q);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // outputs
    //////////////////////////////////////////////////////////////////////

    assign is_inv     = req_held.op == icache_pkg::OP_INVALIDATE;
    assign lookup_hit = state_q == icache_pkg::S_LOOKUP && !is_inv && |hit;
    assign req_ready  = state_q == icache_pkg::S_IDLE;
    assign accept     = req_ready && req_valid;
    assign inv_en     = state_q == icache_pkg::S_LOOKUP && is_inv;
    assign wr_en      = state_q == icache_pkg::S_REFILL;
    assign wr_way     = way_q;
    assign wr_line    = line_q;
    assign use_en     = lookup_hit || wr_en;
    assign use_way    = wr_en ? way_q : hit[1];
    assign mem_req    = state_q == icache_pkg::S_MISS_REQ;
    assign mem_addr.addr = {req_held.addr[31:`ICACHE_INDEX_LSB], {`ICACHE_INDEX_LSB{1'b0}}};
    assign resp_valid = state_q == icache_pkg::S_RESP;
    assign resp       = resp_q;

endmodule

// File: icache_data_array.sv
// icache data array: two ways of full lines, registered read, whole-line refill write
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_data_array (
    input  logic                       clk,
    input  logic                       rd_en,
    input  logic [`ICACHE_INDEX_W-1:0] rd_index,
    input  logic                       wr_en,
    input  logic [`ICACHE_INDEX_W-1:0] wr_index,
    input  logic                       wr_way,
    input  logic [`ICACHE_LINE_W-1:0]  wr_line,
    output logic [`ICACHE_LINE_W-1:0]  line0,
    output logic [`ICACHE_LINE_W-1:0]  line1
);

    logic [`ICACHE_LINE_W-1:0] line_mem [2][`ICACHE_SETS];

    //////////////////////////////////////////////////////////////////////
    // storage
    //////////////////////////////////////////////////////////////////////

    // refill writes the full line into the chosen way
    always_ff @(posedge clk) begin
        if (wr_en) begin
            line_mem[wr_way][wr_index] <= wr_line;
        end
    end

    // both ways read together, outputs hold until the next read
    always_ff @(posedge clk) begin
        if (rd_en) begin
            line0 <= line_mem[0][rd_index];
            line1 <= line_mem[1][rd_index];
        end
    end

endmodule

// File: icache_tag_array.sv
// icache tag array: two-way tags and valid bits, hit compare, per-set LRU and victim choice
`timescale 1ns/100ps
`include "icache_defs.svh"

module icache_tag_array (
    input  logic                       clk,
    input  logic                       rst_n,
    input  logic                       rd_en,
    input  logic [`ICACHE_INDEX_W-1:0] rd_index,
    input  logic [`ICACHE_TAG_W-1:0]   cmp_tag,
    input  logic                       wr_en,
    input  logic [`ICACHE_INDEX_W-1:0] wr_index,
    input  logic                       wr_way,
    input  logic [`ICACHE_TAG_W-1:0]   wr_tag,
    input  logic                       inv_en,
    input  logic [`ICACHE_INDEX_W-1:0] inv_index,
    input  logic                       use_en,
    input  logic                       use_way,
    output logic [1:0]                 hit,
    output logic                       victim_way
);

    logic [`ICACHE_TAG_W-1:0] tag_mem [2][`ICACHE_SETS];
    logic [1:0]               valid   [`ICACHE_SETS];
    // lru bit names the least recently used way of the set
    logic                     lru     [`ICACHE_SETS];

    logic [`ICACHE_TAG_W-1:0] tag_q [2];
    logic [1:0]               valid_q;
    logic                     lru_q;

    // tag storage and tag read
    always_ff @(posedge clk) begin
        if (wr_en) begin
            tag_mem[wr_way][wr_index] <= wr_tag;
        end
        if (rd_en) begin
            tag_q[0] <= tag_mem[0][rd_index];
            tag_q[1] <= tag_mem[1][rd_index];
        end
    end

    //////////////////////////////////////////////////////////////////////
    // valid and lru state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                valid[s] <= 2'b00;
                lru[s]   <= 1'b0;
            end
            valid_q <= 2'b00;
            lru_q   <= 1'b0;
        end else begin
            if (rd_en) begin
                valid_q <= valid[rd_index];
                lru_q   <= lru[rd_index];
            end
            if (wr_en) begin
                valid[wr_index][wr_way] <= 1'b1;
            end
            if (inv_en) begin
                valid[inv_index] <= 2'b00;
            end
            // used way becomes most recent
            if (use_en) begin
                lru[wr_index] <= ~use_way;
            end
        end
    end

    assign hit[0] = valid_q[0] && (tag_q[0] == cmp_tag);
    assign hit[1] = valid_q[1] && (tag_q[1] == cmp_tag);

    // empty way first, way 0 before way 1
    assign victim_way = !valid_q[0] ? 1'b0 :
                        !valid_q[1] ? 1'b1 : lru_q;

endmodule

// File: icache_req_buf.sv
// icache request buffer: holds the accepted fetch request while it is served
`timescale 1ns/100ps

module icache_req_buf (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   accept,
    input  icache_pkg::fetch_req_t req_in,
    output icache_pkg::fetch_req_t req_held
);

    icache_pkg::fetch_req_t req_q;

    //////////////////////////////////////////////////////////////////////
    // capture on accept
    //////////////////////////////////////////////////////////////////////

    // the live bus may change once accepted, so everything downstream
    // works from this copy until the controller goes idle again
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            req_q <= '0;
        end else if (accept) begin
            req_q <= req_in;
        end
    end

    assign req_held = req_q;

endmodule

// File: icache_pkg.sv
// icache shared types: fetch and memory structs, opcode and controller state enums
package icache_pkg;

    // fetch operation
    typedef enum logic {
        OP_FETCH      = 1'b0,
        OP_INVALIDATE = 1'b1
    } icache_op_e;

    // request from fetch stage, word-aligned address
    typedef struct packed {
        icache_op_e  op;
        logic [31:0] addr;
    } fetch_req_t;

    // insn[31:0] is the word at pc, upper word valid only with pair_valid
    typedef struct packed {
        logic [31:0] pc;
        logic [63:0] insn;
        logic        pair_valid;
    } fetch_resp_t;

    // line-aligned refill address
    typedef struct packed {
        logic [31:0] addr;
    } mem_req_t;

    typedef enum logic [2:0] {
        S_IDLE,
        S_LOOKUP,
        S_MISS_REQ,
        S_MISS_WAIT,
        S_REFILL,
        S_RESP
    } ctrl_state_e;

endpackage

// File: icache_defs.svh
// icache geometry: line layout, set count and address field widths
`ifndef ICACHE_DEFS_SVH
`define ICACHE_DEFS_SVH

// word offset within a line, four 32-bit words
`define ICACHE_OFFSET_W 2

// set index, 16 sets
`define ICACHE_INDEX_W 4
`define ICACHE_SETS (1 << `ICACHE_INDEX_W)

// address fields, byte offset takes the low 2 bits
`define ICACHE_INDEX_LSB (`ICACHE_OFFSET_W + 2)
`define ICACHE_TAG_LSB (`ICACHE_INDEX_LSB + `ICACHE_INDEX_W)
`define ICACHE_TAG_W (32 - `ICACHE_INDEX_W - `ICACHE_OFFSET_W - 2)

// one full line as returned by memory
`define ICACHE_LINE_W 128

`endif
